// ==== arcade_frontend.f ====
arcade_pkg.sv
kbd_button_latch.sv
control_mapper.sv
video_out.sv
delta_sigma_dac.sv
arcade_frontend.sv
tb_arcade_frontend.sv

// ==== Bender.yml ====
package:
  name: arcade_frontend

sources:
  - arcade_pkg.sv
  - kbd_button_latch.sv
  - control_mapper.sv
  - video_out.sv
  - delta_sigma_dac.sv
  - arcade_frontend.sv
  - target: test
    files:
      - tb_arcade_frontend.sv

// ==== tb_arcade_frontend.sv ====
/*
 * Arcade frontend testbench
 * Models the host and the game, checks controls, video and audio with assertions
 */
module tb_arcade_frontend;
	timeunit 1ns;
	timeprecision 100ps;

	// Held-key slots of the reference model
	localparam int slot_up     = 0;
	localparam int slot_down   = 1;
	localparam int slot_left   = 2;
	localparam int slot_right  = 3;
	localparam int slot_coin   = 4;
	localparam int slot_start1 = 5;
	localparam int slot_start2 = 6;
	localparam int slot_fire1  = 7;
	localparam int slot_fire2  = 8;
	localparam int audio_window = 65536;
	localparam int wait_limit   = 64;

	logic        clk_sys;
	logic        reset        = 1'b1;
	logic [10:0] ps2_key      = '0;
	logic [7:0]  joystick_0   = '0;
	logic [7:0]  joystick_1   = '0;
	logic [31:0] status       = '0;
	logic [1:0]  host_buttons = '0;
	logic [2:0]  video_r      = '0;
	logic [2:0]  video_g      = '0;
	logic [1:0]  video_b      = '0;
	logic        hsync        = 1'b0;
	logic        vsync        = 1'b0;
	logic        hblank       = 1'b0;
	logic        vblank       = 1'b0;
	logic [7:0]  audio        = '0;
	logic [4:0]  game_joy_a, game_joy_b, game_sw;
	logic        game_reset, ce_pix;
	logic [5:0]  vga_r, vga_g, vga_b;
	logic        vga_hs, vga_vs, audio_l, audio_r;

	// Reference state and run control
	logic [8:0]  key_state   = '0;
	logic        kbd_toggle  = 1'b0;
	logic        checks_on   = 1'b0;
	int          cycle_count = 0;
	integer      seed        = 32'h2d73994d;
	logic [31:0] rnd;

	arcade_frontend dut_i (.*);

	// ========================================================================
	// Clock, cycle count and game video model
	// ========================================================================
	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
	end

	// Game only moves its picture on the pixel enable
	always @(posedge clk_sys) begin
		if (ce_pix) begin
			rnd = $random(seed);
			video_r <= rnd[2:0];
			video_g <= rnd[5:3];
			video_b <= rnd[7:6];
			hblank  <= (rnd[10:8] == 3'd0);
			vblank  <= (rnd[13:11] == 3'd0);
			hsync   <= rnd[14];
			vsync   <= rnd[15];
		end
	end

	// ========================================================================
	// Reference functions
	// ========================================================================
	function automatic int key_slot(input logic [7:0] code);
		case (code)
			arcade_pkg::key_up:     return slot_up;
			arcade_pkg::key_down:   return slot_down;
			arcade_pkg::key_left:   return slot_left;
			arcade_pkg::key_right:  return slot_right;
			arcade_pkg::key_coin:   return slot_coin;
			arcade_pkg::key_start1: return slot_start1;
			arcade_pkg::key_start2: return slot_start2;
			arcade_pkg::key_fire1:  return slot_fire1;
			arcade_pkg::key_fire2:  return slot_fire2;
			default:                return -1;
		endcase
	endfunction

	function automatic logic [4:0] expected_joy(input logic [8:0] keys, input logic [7:0] j0,
		input logic [7:0] j1, input logic [31:0] st);
		logic       up, down, left, right, fire;
		logic [4:0] act;
		up    = keys[slot_up] | j0[arcade_pkg::joy_up] | j1[arcade_pkg::joy_up];
		down  = keys[slot_down] | j0[arcade_pkg::joy_down] | j1[arcade_pkg::joy_down];
		left  = keys[slot_left] | j0[arcade_pkg::joy_left] | j1[arcade_pkg::joy_left];
		right = keys[slot_right] | j0[arcade_pkg::joy_right] | j1[arcade_pkg::joy_right];
		// Only the first fire key and fire buttons fire
		fire  = keys[slot_fire1] | j0[arcade_pkg::joy_fire1] | j1[arcade_pkg::joy_fire1];
		act = '0;
		if (!st[arcade_pkg::status_rotate]) begin
			act[arcade_pkg::game_up]    = left;
			act[arcade_pkg::game_down]  = right;
			act[arcade_pkg::game_left]  = down;
			act[arcade_pkg::game_right] = up;
		end else begin
			act[arcade_pkg::game_up]    = up;
			act[arcade_pkg::game_down]  = down;
			act[arcade_pkg::game_left]  = left;
			act[arcade_pkg::game_right] = right;
		end
		act[arcade_pkg::game_fire] = fire;
		return ~act;
	endfunction

	function automatic logic [4:0] expected_sw(input logic [8:0] keys, input logic [31:0] st);
		logic [4:0] act;
		act = '0;
		act[arcade_pkg::sw_start1] = keys[slot_start1];
		act[arcade_pkg::sw_coin]   = keys[slot_coin];
		act[arcade_pkg::sw_start2] = keys[slot_start2];
		act[arcade_pkg::sw_test_a] = st[arcade_pkg::status_test];
		act[arcade_pkg::sw_test_b] = st[arcade_pkg::status_test];
		return ~act;
	endfunction

	// Three colour bits shown twice
	function automatic logic [5:0] expand_3(input logic [2:0] c, input logic blank);
		if (blank)
			return 6'd0;
		else
			return {c[2], c[1], c[0], c[2], c[1], c[0]};
	endfunction

	// Blue padded by its top bit, then shown twice
	function automatic logic [5:0] expand_blue(input logic [1:0] c, input logic blank);
		if (blank)
			return 6'd0;
		else
			return {c[1], c[0], c[1], c[1], c[0], c[1]};
	endfunction

	// ========================================================================
	// Failure reporting
	// ========================================================================
	task automatic report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display(">>> FAIL");
		$fatal(1, "Check failed");
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display(">>> FAIL");
		$fatal(1, "Timeout");
	endtask

	// ========================================================================
	// Checks
	// ========================================================================
	// Keys two cycles, host words one cycle
	a_joy_map: assert property (@(posedge clk_sys) disable iff (!checks_on)
		game_joy_a == expected_joy($past(key_state, 2), $past(joystick_0), $past(joystick_1),
			$past(status)))
		else report_error("game_joy_a differs from merged controls");

	a_joy_b: assert property (@(posedge clk_sys) disable iff (!checks_on)
		game_joy_b == game_joy_a)
		else report_error("game_joy_b differs from game_joy_a");

	a_sw_map: assert property (@(posedge clk_sys) disable iff (!checks_on)
		game_sw == expected_sw($past(key_state, 2), $past(status)))
		else report_error("game_sw differs from keys and test option");

	a_reset_map: assert property (@(posedge clk_sys) disable iff (cycle_count < 2)
		game_reset == $past(reset | status[arcade_pkg::status_reset_a]
			| status[arcade_pkg::status_reset_b] | host_buttons[1]))
		else report_error("game_reset does not follow its sources");

	// Inactive controls straight out of reset
	a_reset_values: assert property (@(posedge clk_sys) disable iff (cycle_count < 2)
		$past(reset) |-> (game_joy_a == '1 && game_joy_b == '1 && game_sw == '1))
		else report_error("game inputs not all ones after reset");

	a_ce_first: assert property (@(posedge clk_sys)
		$fell(reset) |-> !ce_pix [*4] ##1 ce_pix)
		else report_error("first ce_pix not on fourth edge after reset");

	a_ce_period: assert property (@(posedge clk_sys) disable iff (!checks_on)
		ce_pix |=> !ce_pix ##1 !ce_pix ##1 !ce_pix ##1 ce_pix)
		else report_error("ce_pix period is not 4 cycles");

	a_vga_colour: assert property (@(posedge clk_sys) disable iff (!checks_on)
		ce_pix |=> vga_r == expand_3($past(video_r), $past(hblank | vblank))
			&& vga_g == expand_3($past(video_g), $past(hblank | vblank))
			&& vga_b == expand_blue($past(video_b), $past(hblank | vblank)))
		else report_error("VGA colour differs from expanded game colour");

	a_vga_sync: assert property (@(posedge clk_sys) disable iff (!checks_on)
		ce_pix |=> vga_hs == $past(hsync) && vga_vs == $past(vsync))
		else report_error("VGA sync differs from game sync");

	// Pins hold between pixel enables
	a_vga_hold: assert property (@(posedge clk_sys) disable iff (!checks_on)
		!ce_pix |=> $stable(vga_r) && $stable(vga_g) && $stable(vga_b)
			&& $stable(vga_hs) && $stable(vga_vs))
		else report_error("VGA outputs changed without ce_pix");

	a_audio_mono: assert property (@(posedge clk_sys) disable iff (cycle_count < 2)
		audio_r == audio_l)
		else report_error("audio_r differs from audio_l");

	// ========================================================================
	// Stimulus tasks
	// ========================================================================
	task automatic send_key(input logic [7:0] code, input logic press);
		int slot;
		slot = key_slot(code);
		@(posedge clk_sys);
		kbd_toggle = ~kbd_toggle;
		ps2_key <= {kbd_toggle, press, 1'b0, code};
		if (slot >= 0)
			key_state[slot] <= press;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic drive_host(input logic [7:0] j0, input logic [7:0] j1,
		input logic [31:0] st, input logic [1:0] hb);
		@(posedge clk_sys);
		joystick_0   <= j0;
		joystick_1   <= j1;
		status       <= st;
		host_buttons <= hb;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic wait_game_reset(input logic level);
		int cycles;
		cycles = 0;
		while (game_reset !== level) begin
			if (cycles >= wait_limit) begin
				report_timeout("game_reset level");
			end else begin
				@(negedge clk_sys);
				cycles++;
			end
		end
	endtask

	task automatic wait_ce_pulses(input int count);
		int seen;
		int cycles;
		seen   = 0;
		cycles = 0;
		while (seen < count) begin
			if (cycles >= count * 8) begin
				report_timeout("ce_pix pulses");
			end else begin
				@(negedge clk_sys);
				cycles++;
				if (ce_pix)
					seen++;
			end
		end
	endtask

	task automatic measure_audio(input logic [7:0] sample);
		int high_count;
		int expected;
		high_count = 0;
		expected   = {sample, sample};
		@(posedge clk_sys);
		audio <= sample;
		// First addition of the new sample
		@(posedge clk_sys);
		repeat (audio_window) begin
			@(negedge clk_sys);
			if (audio_l)
				high_count++;
		end
		a_audio_density: assert (high_count == expected)
			else report_error($sformatf("audio %02h gave %0d high cycles, expected %0d",
				sample, high_count, expected));
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial begin
		logic [7:0] codes [10];
		logic [7:0] dir_bit;
		codes = '{arcade_pkg::key_up, arcade_pkg::key_down, arcade_pkg::key_left,
			arcade_pkg::key_right, arcade_pkg::key_coin, arcade_pkg::key_start1,
			arcade_pkg::key_start2, arcade_pkg::key_fire1, arcade_pkg::key_fire2, 8'h1C};
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (4) @(posedge clk_sys);
		checks_on <= 1'b1;

		// Keys held one by one, then let go in the same order
		for (int i = 0; i < 10; i++)
			send_key(codes[i], 1'b1);
		for (int i = 0; i < 10; i++)
			send_key(codes[i], 1'b0);

		// Rotated cabinet first, then straight
		for (int rot = 0; rot < 2; rot++) begin
			for (int d = 0; d < 6; d++) begin
				dir_bit = 8'd1 << d;
				drive_host(dir_bit, 8'd0, rot << arcade_pkg::status_rotate, 2'b00);
				drive_host(8'd0, dir_bit, rot << arcade_pkg::status_rotate, 2'b00);
			end
		end
		drive_host(8'd0, 8'd0, 32'd1 << arcade_pkg::status_test, 2'b00);

		// Each reset source up, then down
		drive_host(8'd0, 8'd0, 32'd1 << arcade_pkg::status_reset_a, 2'b00);
		wait_game_reset(1'b1);
		drive_host(8'd0, 8'd0, 32'd0, 2'b00);
		wait_game_reset(1'b0);
		drive_host(8'd0, 8'd0, 32'd1 << arcade_pkg::status_reset_b, 2'b00);
		wait_game_reset(1'b1);
		drive_host(8'd0, 8'd0, 32'd0, 2'b00);
		wait_game_reset(1'b0);
		drive_host(8'd0, 8'd0, 32'd0, 2'b10);
		wait_game_reset(1'b1);
		drive_host(8'd0, 8'd0, 32'd0, 2'b00);
		wait_game_reset(1'b0);

		wait_ce_pulses(300);

		measure_audio(8'h00);
		measure_audio(8'h40);
		measure_audio(8'hA5);
		measure_audio(8'hFF);

		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== arcade_frontend.sv ====
/*
 * Arcade platform frontend
 * Keyboard, control mapping, video output and audio DAC around the game core
 */
module arcade_frontend #(
	parameter int CE_DIV_BITS = arcade_pkg::ce_div_bits,
	parameter int DAC_BITS    = 16
) (
	input  logic        clk_sys,
	input  logic        reset,
	// Host interface
	input  logic [10:0] ps2_key,
	input  logic [7:0]  joystick_0,
	input  logic [7:0]  joystick_1,
	input  logic [31:0] status,
	input  logic [1:0]  host_buttons,
	// Game controls and reset
	output logic [4:0]  game_joy_a,
	output logic [4:0]  game_joy_b,
	output logic [4:0]  game_sw,
	output logic        game_reset,
	// Game video, valid on ce_pix
	output logic        ce_pix,
	input  logic [2:0]  video_r,
	input  logic [2:0]  video_g,
	input  logic [1:0]  video_b,
	input  logic        hsync,
	input  logic        vsync,
	input  logic        hblank,
	input  logic        vblank,
	// VGA pins
	output logic [5:0]  vga_r,
	output logic [5:0]  vga_g,
	output logic [5:0]  vga_b,
	output logic        vga_hs,
	output logic        vga_vs,
	// Sound
	input  logic [7:0]  audio,
	output logic        audio_l,
	output logic        audio_r
);

	// Held key flags
	logic kb_up, kb_down, kb_left, kb_right;
	logic kb_coin, kb_start1, kb_start2;
	logic kb_fire1, kb_fire2;

	// ========================================================================
	// Controls
	// ========================================================================
	kbd_button_latch kbd_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ps2_key   (ps2_key),
		.kb_up     (kb_up),
		.kb_down   (kb_down),
		.kb_left   (kb_left),
		.kb_right  (kb_right),
		.kb_coin   (kb_coin),
		.kb_start1 (kb_start1),
		.kb_start2 (kb_start2),
		.kb_fire1  (kb_fire1),
		.kb_fire2  (kb_fire2)
	);

	control_mapper ctrl_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.kb_up        (kb_up),
		.kb_down      (kb_down),
		.kb_left      (kb_left),
		.kb_right     (kb_right),
		.kb_coin      (kb_coin),
		.kb_start1    (kb_start1),
		.kb_start2    (kb_start2),
		.kb_fire1     (kb_fire1),
		.kb_fire2     (kb_fire2),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.status       (status),
		.host_buttons (host_buttons),
		.game_joy_a   (game_joy_a),
		.game_joy_b   (game_joy_b),
		.game_sw      (game_sw),
		.game_reset   (game_reset)
	);

	// ========================================================================
	// Video and audio
	// ========================================================================
	video_out #(
		.CE_DIV_BITS (CE_DIV_BITS)
	) video_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.video_r (video_r),
		.video_g (video_g),
		.video_b (video_b),
		.hsync   (hsync),
		.vsync   (vsync),
		.hblank  (hblank),
		.vblank  (vblank),
		.ce_pix  (ce_pix),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	delta_sigma_dac #(
		.DAC_BITS (DAC_BITS)
	) dac_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.audio   (audio),
		.audio_l (audio_l)
	);

	// Mono game, both channels from one modulator
	assign audio_r = audio_l;

endmodule

// ==== delta_sigma_dac.sv ====
/*
 * First-order delta-sigma DAC
 * Sound sample repeated to DAC_BITS, accumulator carry is the audio bit
 */
module delta_sigma_dac #(
	parameter int DAC_BITS = 16
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [7:0] audio,
	output logic       audio_l
);

	// Copies of the byte to fill the accumulator width
	localparam int REPS = DAC_BITS / 8;

	logic [DAC_BITS-1:0] sample;
	logic [DAC_BITS-1:0] acc;
	logic [DAC_BITS:0]   sum;

	// 8'hFF maps to full scale, 8'h00 to zero
	assign sample = {REPS{audio}};

	// Extra top bit is the carry
	assign sum = {1'b0, acc} + {1'b0, sample};

	// ========================================================================
	// Accumulator and output bit
	// ========================================================================
	// Carries per 2**DAC_BITS cycles equal the sample value
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc     <= '0;
			audio_l <= 1'b0;
		end else begin
			acc     <= sum[DAC_BITS-1:0];
			audio_l <= sum[DAC_BITS];
		end
	end

endmodule

// ==== video_out.sv ====
/*
 * Video output stage
 * Pixel enable, colour blanking, 3-3-2 to 6-6-6 expansion and sync alignment
 */
module video_out #(
	parameter int CE_DIV_BITS = 2
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [2:0] video_r,
	input  logic [2:0] video_g,
	input  logic [1:0] video_b,
	input  logic       hsync,
	input  logic       vsync,
	input  logic       hblank,
	input  logic       vblank,
	output logic       ce_pix,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic [CE_DIV_BITS-1:0] div;
	logic                   blank;
	logic [2:0]             r_vis;
	logic [2:0]             g_vis;
	logic [1:0]             b_vis;

	// ========================================================================
	// Pixel clock enable
	// ========================================================================
	// Free-running divider, enable one cycle after the wrap value
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div    <= '0;
			ce_pix <= 1'b0;
		end else begin
			div    <= div + 1'b1;
			ce_pix <= (div == '1);
		end
	end

	// ========================================================================
	// Colour path
	// ========================================================================
	// Black during either blanking interval
	assign blank = hblank | vblank;
	assign r_vis = blank ? 3'd0 : video_r;
	assign g_vis = blank ? 3'd0 : video_g;
	assign b_vis = blank ? 2'd0 : video_b;

	// Sampled on the pixel enable, held until the next one
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else if (ce_pix) begin
			// Bit repeat keeps full scale at both ends
			vga_r  <= {r_vis, r_vis};
			vga_g  <= {g_vis, g_vis};
			// Blue is 2 bits, top bit padded to 3 first
			vga_b  <= {b_vis, b_vis[1], b_vis, b_vis[1]};
			// Sync rides with colour, same latency
			vga_hs <= hsync;
			vga_vs <= vsync;
		end
	end

	// Enable is a single-cycle pulse
	a_ce_single_pulse: assert property (
		@(posedge clk_sys) disable iff (reset)
		ce_pix |=> !ce_pix
	);

endmodule

// ==== control_mapper.sv ====
/*
 * Control mapper
 * Merges keyboard and host joysticks into the active-low game inputs and reset
 */
module control_mapper (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        kb_up,
	input  logic        kb_down,
	input  logic        kb_left,
	input  logic        kb_right,
	input  logic        kb_coin,
	input  logic        kb_start1,
	input  logic        kb_start2,
	input  logic        kb_fire1,
	input  logic        kb_fire2,
	input  logic [7:0]  joystick_0,
	input  logic [7:0]  joystick_1,
	input  logic [31:0] status,
	input  logic [1:0]  host_buttons,
	output logic [4:0]  game_joy_a,
	output logic [4:0]  game_joy_b,
	output logic [4:0]  game_sw,
	output logic        game_reset
);

	logic       up_raw, down_raw, left_raw, right_raw;
	logic       fire_raw;
	logic       rotated;
	logic [4:0] joy_next;
	logic [4:0] sw_next;
	logic       reset_next;

	// Keyboard plus both players' sticks, active high
	assign up_raw    = kb_up | joystick_0[arcade_pkg::joy_up]
		| joystick_1[arcade_pkg::joy_up];
	assign down_raw  = kb_down | joystick_0[arcade_pkg::joy_down]
		| joystick_1[arcade_pkg::joy_down];
	assign left_raw  = kb_left | joystick_0[arcade_pkg::joy_left]
		| joystick_1[arcade_pkg::joy_left];
	assign right_raw = kb_right | joystick_0[arcade_pkg::joy_right]
		| joystick_1[arcade_pkg::joy_right];

	// Game has one button, taken from the first fire input only
	assign fire_raw = kb_fire1
		| joystick_0[arcade_pkg::joy_fire1] | joystick_1[arcade_pkg::joy_fire1];

	// Option off means a vertical cabinet turned on its side
	assign rotated = ~status[arcade_pkg::status_rotate];

	// ========================================================================
	// Next values, still active high
	// ========================================================================
	always_comb begin
		joy_next = '0;
		if (rotated) begin
			joy_next[arcade_pkg::game_up]    = left_raw;
			joy_next[arcade_pkg::game_down]  = right_raw;
			joy_next[arcade_pkg::game_left]  = down_raw;
			joy_next[arcade_pkg::game_right] = up_raw;
		end else begin
			joy_next[arcade_pkg::game_up]    = up_raw;
			joy_next[arcade_pkg::game_down]  = down_raw;
			joy_next[arcade_pkg::game_left]  = left_raw;
			joy_next[arcade_pkg::game_right] = right_raw;
		end
		joy_next[arcade_pkg::game_fire] = fire_raw;

		// Test option drives both test switches
		sw_next                        = '0;
		sw_next[arcade_pkg::sw_start1] = kb_start1;
		sw_next[arcade_pkg::sw_coin]   = kb_coin;
		sw_next[arcade_pkg::sw_test_a] = status[arcade_pkg::status_test];
		sw_next[arcade_pkg::sw_start2] = kb_start2;
		sw_next[arcade_pkg::sw_test_b] = status[arcade_pkg::status_test];
	end

	// Reset menu entries and the host reset button
	assign reset_next = status[arcade_pkg::status_reset_a]
		| status[arcade_pkg::status_reset_b] | host_buttons[1];

	// Registered, inverted to active low
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game_joy_a <= '1;
			game_joy_b <= '1;
			game_sw    <= '1;
			game_reset <= 1'b1;
		end else begin
			game_joy_a <= ~joy_next;
			game_joy_b <= ~joy_next;
			game_sw    <= ~sw_next;
			game_reset <= reset_next;
		end
	end

	// Both game ports see the same merged controls
	a_joy_ports_equal: assert property (
		@(posedge clk_sys) disable iff (reset)
		game_joy_a == game_joy_b
	);

endmodule

// ==== kbd_button_latch.sv ====
/*
 * Keyboard button latch
 * Turns toggle-marked key events into one held pressed flag per game key
 */
module kbd_button_latch (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	output logic        kb_up,
	output logic        kb_down,
	output logic        kb_left,
	output logic        kb_right,
	output logic        kb_coin,
	output logic        kb_start1,
	output logic        kb_start2,
	output logic        kb_fire1,
	output logic        kb_fire2
);

	// Flag slots inside the held vector
	localparam int f_up     = 0;
	localparam int f_down   = 1;
	localparam int f_left   = 2;
	localparam int f_right  = 3;
	localparam int f_coin   = 4;
	localparam int f_start1 = 5;
	localparam int f_start2 = 6;
	localparam int f_fire1  = 7;
	localparam int f_fire2  = 8;

	logic [8:0] flags;
	logic       toggle_q;
	logic       kbd_event;
	logic       pressed;
	logic [7:0] code;

	// Event word fields
	assign pressed = ps2_key[arcade_pkg::kbd_pressed_bit];
	assign code    = ps2_key[7:0];

	// New event whenever toggle differs from last copy
	assign kbd_event = ps2_key[arcade_pkg::kbd_toggle_bit] != toggle_q;

	// ========================================================================
	// Toggle tracking and flag update
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		// Copy tracks the toggle also during reset, so no stale event after it
		toggle_q <= ps2_key[arcade_pkg::kbd_toggle_bit];
		if (reset) begin
			flags <= '0;
		end else if (kbd_event) begin
			case (code)
				arcade_pkg::key_up:     flags[f_up]     <= pressed;
				arcade_pkg::key_down:   flags[f_down]   <= pressed;
				arcade_pkg::key_left:   flags[f_left]   <= pressed;
				arcade_pkg::key_right:  flags[f_right]  <= pressed;
				arcade_pkg::key_coin:   flags[f_coin]   <= pressed;
				arcade_pkg::key_start1: flags[f_start1] <= pressed;
				arcade_pkg::key_start2: flags[f_start2] <= pressed;
				arcade_pkg::key_fire1:  flags[f_fire1]  <= pressed;
				arcade_pkg::key_fire2:  flags[f_fire2]  <= pressed;
				// Other keys are of no interest to the game
				default: ;
			endcase
		end
	end

	// Flag outputs
	assign kb_up     = flags[f_up];
	assign kb_down   = flags[f_down];
	assign kb_left   = flags[f_left];
	assign kb_right  = flags[f_right];
	assign kb_coin   = flags[f_coin];
	assign kb_start1 = flags[f_start1];
	assign kb_start2 = flags[f_start2];
	assign kb_fire1  = flags[f_fire1];
	assign kb_fire2  = flags[f_fire2];

	// One event carries one scan code, so one flag at most
	a_one_flag_per_cycle: assert property (
		@(posedge clk_sys) disable iff (reset)
		$countones(flags ^ $past(flags)) <= 1
	);

endmodule

// ==== arcade_pkg.sv ====
/*
 * Arcade frontend shared definitions
 * Scan codes, host and game control bit positions, divider width
 */
package arcade_pkg;

	// ========================================================================
	// Keyboard scan codes (set 2, make codes)
	// ========================================================================
	localparam logic [7:0] key_up     = 8'h75;
	localparam logic [7:0] key_down   = 8'h72;
	localparam logic [7:0] key_left   = 8'h6B;
	localparam logic [7:0] key_right  = 8'h74;
	// ESC
	localparam logic [7:0] key_coin   = 8'h76;
	// F1 and F2
	localparam logic [7:0] key_start1 = 8'h05;
	localparam logic [7:0] key_start2 = 8'h06;
	// Space and Alt
	localparam logic [7:0] key_fire1  = 8'h29;
	localparam logic [7:0] key_fire2  = 8'h11;

	// Keyboard event word, scan code in bits 7..0
	localparam int kbd_toggle_bit  = 10;
	localparam int kbd_pressed_bit = 9;

	// ========================================================================
	// Host joystick word, active high
	// ========================================================================
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire1 = 4;
	localparam int joy_fire2 = 5;

	// Game joystick word, active low
	localparam int game_up    = 0;
	localparam int game_down  = 1;
	localparam int game_left  = 2;
	localparam int game_right = 3;
	localparam int game_fire  = 4;

	// Game switch word, active low
	localparam int sw_start1 = 0;
	localparam int sw_coin   = 1;
	localparam int sw_test_a = 2;
	localparam int sw_start2 = 3;
	localparam int sw_test_b = 4;

	// Host option status bits
	localparam int status_reset_a = 0;
	localparam int status_test    = 1;
	localparam int status_rotate  = 2;
	localparam int status_reset_b = 6;

	// Pixel enable divider width, divide by 4
	localparam int ce_div_bits = 2;

endpackage
